// File: dv/controllerTb.sv
`default_nettype none

module controllerTb import rvIsaPkg::*, ctrlPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int numRand     = 200;                       // Random decode checks
  localparam int testCycles  = 4 + 2 * numRand + 16 + 52 + 12 + 10;
  localparam int clkPeriodNs = 40;

  logic clk, rst;
  logic StallD, StallE, StallM, StallW, FlushD, FlushE, FlushM, FlushW;
  instrT InstrD;
  logic IllegalIEUInstrD;
  logic [1:0] FlagsE;
  immSrcT ImmSrcD;
  logic JumpD, BranchD, IllegalBaseInstrD, LoadStallD, StoreStallD, StructuralStallD;
  logic InstrValidD, InstrValidE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, SubArithE;
  regAddrT Rs1E, Rs2E, RdE, RdM, RdW;
  aluSelT ALUSelectE;
  logic JumpE, BranchE, BranchSignedE, PCSrcE;
  memRwT MemRWE, MemRWM;
  resultSrcT ResultSrcE, ResultSrcW;
  funct3T Funct3E, Funct3M;
  fwdSelT ForwardAE, ForwardBE;
  logic InstrValidM, RegWriteM, CSRReadM, CSRWriteM, PrivilegedM;
  logic InvalidateICacheM, FlushDCacheM, CSRWriteFenceM, RegWriteW;

  int errCount;
  int testsPassed, testsFailed;
  int errAtStart;
  opcodeT opList [12];

  controller u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  initial begin  // Watchdog
    #(testCycles * clkPeriodNs * 3 / 2);
    $display("Timeout: tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // Helpers

  function automatic instrT encode(funct7T f7, regAddrT rs2, regAddrT rs1, funct3T f3,
                                   regAddrT rd, opcodeT op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Expected {ImmSrc, Jump, Branch, Illegal} from the RV32I encoding rules
  function automatic logic [5:0] refDecode(instrT ins);
    opcodeT op;
    funct3T f3;
    funct7T f7;
    logic   legal;
    immSrcT imm;
    op = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    legal = 1'b0;
    imm = immI;
    case (op)
      opLoad:    legal = (f3 != 3'd3) && (f3 < 3'd6);
      opMiscMem: legal = (f3 <= 3'd1);               // fence, fence.i
      opOpImm:   legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                         (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      opAuipc:   begin legal = 1'b1; imm = immU; end
      opStore:   begin legal = (f3 < 3'd3); imm = immS; end
      opOp:      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      opLui:     begin legal = 1'b1; imm = immU; end
      opBranch:  begin legal = (f3 != 3'd2) && (f3 != 3'd3); imm = immB; end
      opJalr:    legal = (f3 == 3'd0);
      opJal:     begin legal = 1'b1; imm = immJ; end
      opSystem:  legal = (f3 == 3'd0 && ins[11:7] == 5'd0) || (f3[1:0] != 2'b00);
      default:   legal = 1'b0;
    endcase
    if (!legal) imm = immI;                          // Illegal rows are all zero
    return {imm, legal && (op == opJal || op == opJalr), legal && (op == opBranch), !legal};
  endfunction

  // Branch outcome by mnemonic
  function automatic logic branchTaken(int f3, logic eq, logic lt);
    logic t;
    case (f3)
      0:       t = eq;   // beq
      1:       t = !eq;  // bne
      4, 6:    t = lt;   // blt, bltu
      5, 7:    t = !lt;  // bge, bgeu
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  task automatic checkVal(string name, logic [31:0] expVal, logic [31:0] actVal);
    assert (actVal === expVal) else begin
      $display("Fail %s expected %0h actual %0h", name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic step();  // Next edge plus drive skew
    @(posedge clk);
    #2;
  endtask

  task automatic finishTest(string name);
    if (errCount == errAtStart) begin
      testsPassed++;
      $display("Test %s done, ok", name);
    end else begin
      testsFailed++;
      $display("Test %s done, %0d errors", name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  //////////////////////////////
  // Stimulus

  initial begin
    instrT ins;
    logic [5:0] expDec;
    logic taken;
    rst = 1'b1;
    {StallD, StallE, StallM, StallW, FlushD, FlushE, FlushM, FlushW} = '0;
    InstrD = '0;
    IllegalIEUInstrD = 1'b0;
    FlagsE = 2'b00;
    errCount = 0;
    errAtStart = 0;
    testsPassed = 0;
    testsFailed = 0;
    void'($urandom(32'h4565_14ea));
    opList = '{opLoad, opMiscMem, opOpImm, opAuipc, opStore, opOp, opLui, opBranch,
               opJalr, opJal, opSystem, 7'b1111111};
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
    #1;
    checkVal("resetRegWriteW", 0, RegWriteW);
    checkVal("resetMemRWM", 0, MemRWM);
    checkVal("resetPCSrcE", 0, PCSrcE);
    checkVal("resetCSRWriteFenceM", 0, CSRWriteFenceM);
    checkVal("resetInstrValidE", 0, InstrValidE);
    checkVal("resetInstrValidD", 0, InstrValidD);
    finishTest("resetState");

    for (int i = 0; i < numRand; i++) begin  // Random decode against the table
      step();
      ins = $urandom;
      ins[6:0] = opList[$urandom % 12];
      if ($urandom % 2) ins[31:25] = ($urandom % 2) ? 7'h20 : 7'h00;  // Hit legal funct7
      if ($urandom % 2) ins[11:7] = 5'd0;
      InstrD = ins;
      #1 expDec = refDecode(ins);
      checkVal("decodeImmSrc", expDec[5:3], ImmSrcD);
      checkVal("decodeJump", expDec[2], JumpD);
      checkVal("decodeBranch", expDec[1], BranchD);
      checkVal("decodeIllegal", expDec[0], IllegalBaseInstrD);
    end
    IllegalIEUInstrD = 1'b1;
    for (int i = 0; i < numRand; i++) begin  // Upstream illegal squashes all
      step();
      checkVal("squashExecute", 0, {ALUSrcAE, ALUSrcBE, ALUResultSrcE, SubArithE, ALUSelectE,
                                    JumpE, BranchE, MemRWE, ResultSrcE});  // Previous word
      InstrD = $urandom;
      InstrD[6:0] = opList[$urandom % 11];
      #1;
      checkVal("squashImmSrc", 0, ImmSrcD);
      checkVal("squashJumpBranch", 0, {JumpD, BranchD});
      checkVal("squashRegWrite", 0, u_dut.RegWriteD);
      checkVal("squashMemRW", 0, u_dut.MemRWD);
      checkVal("squashCsr", 0, {u_dut.CSRReadD, u_dut.CSRWriteD});
    end
    IllegalIEUInstrD = 1'b0;
    InstrD = '0;                                              // Illegal word, no write
    finishTest("decodeTable");

    step();
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd5, opOpImm);  // addi x5
    step();
    checkVal("pipeRdE", 5, RdE);
    checkVal("pipeRs1E", 1, Rs1E);
    checkVal("pipeALUSrcBE", 1, ALUSrcBE);
    checkVal("pipeInstrValidE", 1, InstrValidE);
    checkVal("pipeInstrValidD", 1, InstrValidD);
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, opMiscMem);  // fence, no write
    step();
    checkVal("pipeNotYetW", 0, RegWriteW);
    step();
    checkVal("pipeRegWriteW", 1, RegWriteW);
    checkVal("pipeRdW", 5, RdW);
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd7, opOpImm);  // addi x7
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, opMiscMem);
    step();
    StallM = 1'b1;                                            // x7 sits in Memory
    step();
    step();
    checkVal("stallRdM", 7, RdM);
    checkVal("stallRegWriteM", 1, RegWriteM);
    StallM = 1'b0;
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd9, opOpImm);  // addi x9, bubbled on entry
    FlushE = 1'b1;
    step();
    FlushE = 1'b0;
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, opMiscMem);
    checkVal("flushInstrValidE", 0, InstrValidE);
    step();
    checkVal("flushRegWriteM", 0, RegWriteM);
    finishTest("pipelineTiming");

    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 == 2 || f3 == 3) continue;
      for (int fl = 0; fl < 4; fl++) begin
        step();
        FlagsE = 2'b00;
        InstrD = encode(7'h00, 5'd2, 5'd1, f3[2:0], 5'd0, opBranch);
        step();
        FlagsE = fl[1:0];                                       // {eq, lt}
        #1 taken = branchTaken(f3, fl[1], fl[0]);
        checkVal($sformatf("branchF3_%0d_flags%0d", f3, fl), taken, PCSrcE);
        if (fl == 0) begin
          checkVal($sformatf("branchSignedF3_%0d", f3), {1'b1, (f3 < 6)},
                   {BranchE, BranchSignedE});                   // Unsigned only bltu/bgeu
        end
      end
    end
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, opJal);
    step();
    FlagsE = 2'b00;
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd1, opJalr);
    #1 checkVal("jalPCSrc", 1, PCSrcE);
    checkVal("jalJumpE", 1, JumpE);
    step();
    #1 checkVal("jalrPCSrc", 1, PCSrcE);
    finishTest("branchResolution");

    step();
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd6, opOpImm);   // addi x6
    step();
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd6, opOpImm);   // addi x6 again
    step();
    InstrD = encode(7'h00, 5'd0, 5'd6, 3'd0, 5'd0, opOp);      // add x0, x6, x0 writes x0
    step();
    checkVal("fwdBothMatch", fwdFromM, ForwardAE);
    InstrD = encode(7'h00, 5'd6, 5'd0, 3'd0, 5'd3, opOp);      // add x3, x0, x6
    step();
    checkVal("fwdOnlyW", fwdFromW, ForwardBE);
    checkVal("fwdX0", fwdNone, ForwardAE);                     // Memory writes x0 here
    checkVal("fwdRs2E", 6, Rs2E);
    finishTest("forwarding");

    step();
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd10, opLoad);   // lw x10
    step();
    InstrD = encode(7'h00, 5'd0, 5'd10, 3'd2, 5'd4, opOp);     // slt x4, x10, x0
    #1 checkVal("loadStall", 1, LoadStallD);
    checkVal("loadStructStall", 1, StructuralStallD);
    checkVal("loadMemRWE", memRead, MemRWE);
    checkVal("loadResultSrcE", resMem, ResultSrcE);
    checkVal("loadFunct3E", 2, Funct3E);
    step();
    checkVal("sltSubArithE", 1, SubArithE);
    checkVal("sltALUSelectE", 3'b010, ALUSelectE);
    checkVal("loadMemRWM", memRead, MemRWM);
    InstrD = encode(7'h00, 5'd3, 5'd1, 3'd2, 5'd0, opStore);   // sw
    step();
    InstrD = encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd11, opLoad);   // lw x11
    #1 checkVal("storeStall", 1, StoreStallD);
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd2, 5'd5, opSystem);  // csrrs x5, csr, x0
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd1, 5'd0, opMiscMem); // fence.i
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, opSystem);  // ecall
    checkVal("csrReadOnlyRead", 1, CSRReadM);
    checkVal("csrReadOnlyWrite", 0, CSRWriteM);
    checkVal("csrFunct3M", 2, Funct3M);
    checkVal("csrInstrValidM", 1, InstrValidM);
    step();
    InstrD = encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, opMiscMem);
    checkVal("fenceIWriteFence", 1, CSRWriteFenceM);
    checkVal("fenceIInvalidate", 1, InvalidateICacheM);
    checkVal("fenceIFlushDCache", 1, FlushDCacheM);
    checkVal("csrResultSrcW", resCsr, ResultSrcW);
    step();
    checkVal("ecallPrivilegedM", 1, PrivilegedM);
    finishTest("stalls");

    $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/controller.sv
`default_nettype none

module controller import rvIsaPkg::*, ctrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       StallD, StallE, StallM, StallW,  // From stall/flush control
  input  logic       FlushD, FlushE, FlushM, FlushW,
  // Decode
  input  instrT      InstrD,
  input  logic       IllegalIEUInstrD,
  output immSrcT     ImmSrcD,
  output logic       JumpD, BranchD, IllegalBaseInstrD,
  output logic       LoadStallD, StoreStallD, StructuralStallD,
  // Execute
  input  logic [1:0] FlagsE,                          // {eq, lt}
  output logic       InstrValidD, InstrValidE,
  output regAddrT    Rs1E, Rs2E, RdE,
  output logic       ALUSrcAE, ALUSrcBE, ALUResultSrcE, SubArithE,
  output aluSelT     ALUSelectE,
  output logic       JumpE, BranchE, BranchSignedE, PCSrcE,
  output memRwT      MemRWE,
  output resultSrcT  ResultSrcE,
  output funct3T     Funct3E,
  output fwdSelT     ForwardAE, ForwardBE,
  // Memory
  output logic       InstrValidM, RegWriteM,
  output regAddrT    RdM,
  output memRwT      MemRWM,
  output funct3T     Funct3M,
  output logic       CSRReadM, CSRWriteM, PrivilegedM,
  output logic       InvalidateICacheM, FlushDCacheM, CSRWriteFenceM,
  // Writeback
  output regAddrT    RdW,
  output logic       RegWriteW,
  output resultSrcT  ResultSrcW
);

  regAddrT   Rs1D, Rs2D, RdD;   // Decode to pipe and hazard unit
  funct3T    Funct3D;
  aluSelT    ALUSelectD;
  memRwT     MemRWD;
  resultSrcT ResultSrcD;
  logic      RegWriteD, ALUSrcAD, ALUSrcBD, ALUResultSrcD, SubArithD;
  logic      CSRReadD, CSRWriteD, PrivilegedD, FenceID;

  instrDecoder uDecoder (.*);   // Decode stage, combinational
  ctrlPipe     uPipe    (.*);   // E/M/W control registers, branch
  hazardUnit   uHazard  (.*);   // Forwarding and stall detect

endmodule

`default_nettype wire

// File: rtl/ctrlPipe.sv
`default_nettype none

module ctrlPipe import rvIsaPkg::*, ctrlPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      StallD, StallE, StallM, StallW,
  input  logic      FlushD, FlushE, FlushM, FlushW,
  input  logic [1:0] FlagsE,                 // {eq, lt} from comparator
  // Decode stage
  input  regAddrT   Rs1D, Rs2D, RdD,
  input  funct3T    Funct3D,
  input  aluSelT    ALUSelectD,
  input  memRwT     MemRWD,
  input  resultSrcT ResultSrcD,
  input  logic      RegWriteD, ALUSrcAD, ALUSrcBD, ALUResultSrcD, SubArithD,
  input  logic      JumpD, BranchD, CSRReadD, CSRWriteD, PrivilegedD, FenceID,
  // Execute stage
  output logic      InstrValidD, InstrValidE,
  output regAddrT   Rs1E, Rs2E, RdE,
  output logic      ALUSrcAE, ALUSrcBE, ALUResultSrcE,
  output aluSelT    ALUSelectE,
  output logic      SubArithE, JumpE, BranchE,
  output logic      BranchSignedE,           // Signed compare for blt/bge
  output logic      PCSrcE,                  // Redirect fetch
  output memRwT     MemRWE,
  output resultSrcT ResultSrcE,
  output funct3T    Funct3E,
  // Memory stage
  output logic      InstrValidM,
  output regAddrT   RdM,
  output logic      RegWriteM,
  output memRwT     MemRWM,
  output funct3T    Funct3M,
  output logic      CSRReadM, CSRWriteM, PrivilegedM,
  output logic      InvalidateICacheM, FlushDCacheM,
  output logic      CSRWriteFenceM,          // Flush younger stages
  // Writeback stage
  output regAddrT   RdW,
  output logic      RegWriteW,
  output resultSrcT ResultSrcW
);

  logic      regWriteE, csrReadE, csrWriteE, privilegedE, fenceIE;
  logic      fenceIM;
  resultSrcT resultSrcM;
  logic      eqE, ltE, branchFlagE;

  //////////////////////////////
  // Stage registers

  always_ff @(posedge clk) begin
    if (rst | FlushD) begin
      InstrValidD <= 1'b0;
    end else if (~StallD) begin
      InstrValidD <= 1'b1;  // Fetch delivered a new word
    end
  end

  always_ff @(posedge clk) begin
    if (rst | FlushE) begin  // Flush beats stall, bubble
      {InstrValidE, Rs1E, Rs2E, RdE, regWriteE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, ALUSelectE,
       SubArithE, JumpE, BranchE, MemRWE, ResultSrcE, Funct3E, csrReadE, csrWriteE,
       privilegedE, fenceIE} <= '0;
    end else if (~StallE) begin
      {InstrValidE, Rs1E, Rs2E, RdE, regWriteE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, ALUSelectE,
       SubArithE, JumpE, BranchE, MemRWE, ResultSrcE, Funct3E, csrReadE, csrWriteE,
       privilegedE, fenceIE} <=
      {InstrValidD, Rs1D, Rs2D, RdD, RegWriteD, ALUSrcAD, ALUSrcBD, ALUResultSrcD, ALUSelectD,
       SubArithD, JumpD, BranchD, MemRWD, ResultSrcD, Funct3D, CSRReadD, CSRWriteD,
       PrivilegedD, FenceID};
    end
  end

  always_ff @(posedge clk) begin
    if (rst | FlushM) begin
      {InstrValidM, RdM, RegWriteM, MemRWM, Funct3M, CSRReadM, CSRWriteM, PrivilegedM,
       fenceIM, resultSrcM} <= '0;
    end else if (~StallM) begin
      {InstrValidM, RdM, RegWriteM, MemRWM, Funct3M, CSRReadM, CSRWriteM, PrivilegedM,
       fenceIM, resultSrcM} <=
      {InstrValidE, RdE, regWriteE, MemRWE, Funct3E, csrReadE, csrWriteE, privilegedE,
       fenceIE, ResultSrcE};
    end
  end

  always_ff @(posedge clk) begin
    if (rst | FlushW) begin
      {RdW, RegWriteW, ResultSrcW} <= '0;
    end else if (~StallW) begin
      {RdW, RegWriteW, ResultSrcW} <= {RdM, RegWriteM, resultSrcM};
    end
  end

  //////////////////////////////
  // Branch resolution

  assign {eqE, ltE}    = FlagsE;
  assign branchFlagE   = Funct3E[2] ? ltE : eqE;               // blt/bge family vs beq/bne
  assign PCSrcE        = JumpE | (BranchE & (branchFlagE ^ Funct3E[0]));  // Bit 0 inverts
  assign BranchSignedE = BranchE & (Funct3E[2:1] != 2'b11);    // Not bltu/bgeu

  // fence.i invalidates I$ after writing back D$
  assign InvalidateICacheM = fenceIM;
  assign FlushDCacheM      = fenceIM;
  assign CSRWriteFenceM    = CSRWriteM | fenceIM;

endmodule

`default_nettype wire

// File: rtl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  //////////////////////////////
  // Datapath selects

  typedef logic [2:0] immSrcT;  // Immediate format for the extender
  localparam immSrcT immI = 3'b000;
  localparam immSrcT immS = 3'b001;
  localparam immSrcT immB = 3'b010;
  localparam immSrcT immJ = 3'b011;
  localparam immSrcT immU = 3'b100;

  typedef logic [2:0] resultSrcT;  // Writeback mux select
  localparam resultSrcT resAlu = 3'b000;
  localparam resultSrcT resMem = 3'b001;  // Load data
  localparam resultSrcT resCsr = 3'b010;  // CSR read data

  typedef logic [2:0] aluSelT;       // ALU output mux, funct3 coded
  localparam aluSelT aluAdd = 3'b000;  // Address generation

  //////////////////////////////
  // Memory access

  typedef logic [1:0] memRwT;  // {read, write}
  localparam memRwT memNone  = 2'b00;
  localparam memRwT memWrite = 2'b01;
  localparam memRwT memRead  = 2'b10;
  localparam int    memRdBit = 1;
  localparam int    memWrBit = 0;

  //////////////////////////////
  // Hazard selects

  typedef logic [1:0] fwdSelT;  // Operand forwarding mux
  localparam fwdSelT fwdNone  = 2'b00;  // Register file value
  localparam fwdSelT fwdFromW = 2'b01;
  localparam fwdSelT fwdFromM = 2'b10;

  // Main decoder row: RegWrite, ImmSrc, ALUSrcA/B, MemRW, ResultSrc,
  // Branch, ALUOp, Jump, ALUResultSrc, CSRRead, Privileged, Fence, Illegal
  typedef logic [18:0] ctrlWordT;

endpackage

`default_nettype wire

// File: rtl/hazardUnit.sv
`default_nettype none

module hazardUnit import rvIsaPkg::*, ctrlPkg::*; (
  input  regAddrT   Rs1D, Rs2D,          // Decode sources
  input  regAddrT   Rs1E, Rs2E, RdE,
  input  regAddrT   RdM, RdW,
  input  logic      RegWriteM, RegWriteW,
  input  memRwT     MemRWD, MemRWE,
  input  resultSrcT ResultSrcE,
  output fwdSelT    ForwardAE, ForwardBE,
  output logic      LoadStallD,          // Load-use, also counted by perf counters
  output logic      StoreStallD,         // Load behind a store
  output logic      StructuralStallD
);

  logic matchDE;       // Decode source needs Execute result
  logic csrRdStallD;

  // Memory result is newer than Writeback, so it wins
  function automatic fwdSelT fwdSel(input regAddrT rs);
    fwdSelT sel;
    if (rs == regZero) begin
      sel = fwdNone;  // x0 never forwards
    end else if (RegWriteM & (rs == RdM)) begin
      sel = fwdFromM;
    end else if (RegWriteW & (rs == RdW)) begin
      sel = fwdFromW;
    end else begin
      sel = fwdNone;
    end
    return sel;
  endfunction

  //////////////////////////////
  // Forwarding

  always_comb begin
    ForwardAE = fwdSel(Rs1E);
    ForwardBE = fwdSel(Rs2E);
  end

  //////////////////////////////
  // Stalls

  assign matchDE = ((Rs1D == RdE) | (Rs2D == RdE)) & (RdE != regZero);
  assign LoadStallD  = MemRWE[memRdBit] & matchDE;      // Load data only ready in Memory
  assign StoreStallD = MemRWD[memRdBit] & MemRWE[memWrBit];
  assign csrRdStallD = (ResultSrcE == resCsr) & matchDE;  // CSR read data also late
  assign StructuralStallD = LoadStallD | StoreStallD | csrRdStallD;

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
`default_nettype none

module instrDecoder import rvIsaPkg::*, ctrlPkg::*; (
  input  instrT     InstrD,             // Instruction in Decode
  input  logic      IllegalIEUInstrD,   // Upstream illegal, squash everything
  output regAddrT   Rs1D, Rs2D, RdD,    // Register fields
  output funct3T    Funct3D,
  output immSrcT    ImmSrcD,
  output aluSelT    ALUSelectD,
  output memRwT     MemRWD,
  output resultSrcT ResultSrcD,
  output logic      RegWriteD,
  output logic      ALUSrcAD, ALUSrcBD,  // A: PC instead of rs1, B: imm instead of rs2
  output logic      BranchD, JumpD,
  output logic      ALUResultSrcD,       // Pass PC+4/imm instead of ALU result
  output logic      SubArithD,           // Invert B or arithmetic shift
  output logic      CSRReadD, CSRWriteD,
  output logic      PrivilegedD,
  output logic      FenceID,
  output logic      IllegalBaseInstrD
);

  opcodeT   opD;
  funct7T   funct7D;
  ctrlWordT ctrlWordD;                     // Main table row
  logic     f7ZeroD, f7AltD;
  logic     iFunctD, rFunctD, lFunctD, sFunctD, bFunctD;  // Legal funct per opcode
  logic     jrFunctD, fenceFunctD, pFunctD, csrFunctD;
  logic     aluOpD;                        // Use funct3 rather than add
  logic     fenceXD;                       // fence or fence.i
  logic     subD, sraD, sltD, sltuD;

  assign opD     = InstrD[6:0];
  assign Funct3D = InstrD[14:12];
  assign funct7D = InstrD[31:25];
  assign Rs1D    = InstrD[19:15];
  assign Rs2D    = InstrD[24:20];
  assign RdD     = InstrD[11:7];

  //////////////////////////////
  // Strict legality

  assign f7ZeroD     = (funct7D == funct7Zero);
  assign f7AltD      = (funct7D == funct7Alt);
  assign iFunctD     = ((Funct3D != f3Sll) & (Funct3D != f3Sr)) |   // Non-shifts
                       ((Funct3D == f3Sll) & f7ZeroD) |
                       ((Funct3D == f3Sr) & (f7ZeroD | f7AltD));    // srli, srai
  assign rFunctD     = f7ZeroD | (((Funct3D == f3AddSub) | (Funct3D == f3Sr)) & f7AltD);
  assign lFunctD     = Funct3D inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  assign sFunctD     = Funct3D inside {3'b000, 3'b001, 3'b010};
  assign bFunctD     = (Funct3D[2:1] != 2'b01);  // 010, 011 unused
  assign jrFunctD    = (Funct3D == f3AddSub);
  assign fenceFunctD = (Funct3D == f3Fence) | (Funct3D == f3FenceI);
  assign pFunctD     = (Funct3D == f3Priv) & (RdD == regZero);
  assign csrFunctD   = (Funct3D[1:0] != 2'b00);  // csrrw/s/c and imm forms

  //////////////////////////////
  // Main control table

  // Low byte: Branch ALUOp Jump ALUResultSrc CSRRead Privileged Fence Illegal
  always_comb begin
    ctrlWordD = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0001};  // Illegal by default
    case (opD)
      opLoad:    if (lFunctD)
                   ctrlWordD = {1'b1, immI, 2'b01, memRead, resMem, 8'b0000_0000};
      opMiscMem: if (fenceFunctD)
                   ctrlWordD = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0010};
      opOpImm:   if (iFunctD)
                   ctrlWordD = {1'b1, immI, 2'b01, memNone, resAlu, 8'b0100_0000};
      opAuipc:     ctrlWordD = {1'b1, immU, 2'b11, memNone, resAlu, 8'b0000_0000};
      opStore:   if (sFunctD)
                   ctrlWordD = {1'b0, immS, 2'b01, memWrite, resAlu, 8'b0000_0000};
      opOp:      if (rFunctD)
                   ctrlWordD = {1'b1, immI, 2'b00, memNone, resAlu, 8'b0100_0000};
      opLui:       ctrlWordD = {1'b1, immU, 2'b01, memNone, resAlu, 8'b0001_0000};
      opBranch:  if (bFunctD)
                   ctrlWordD = {1'b0, immB, 2'b11, memNone, resAlu, 8'b1000_0000};
      opJalr:    if (jrFunctD)
                   ctrlWordD = {1'b1, immI, 2'b01, memNone, resAlu, 8'b0011_0000};
      opJal:       ctrlWordD = {1'b1, immJ, 2'b11, memNone, resAlu, 8'b0011_0000};
      opSystem:  if (pFunctD)  // Decoded further in the privilege unit
                   ctrlWordD = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0100};
                 else if (csrFunctD)
                   ctrlWordD = {1'b1, immI, 2'b00, memNone, resCsr, 8'b0000_1000};
      default:   ctrlWordD = {1'b0, immI, 2'b00, memNone, resAlu, 8'b0000_0001};
    endcase
  end

  assign {RegWriteD, ImmSrcD, ALUSrcAD, ALUSrcBD, MemRWD, ResultSrcD, BranchD, aluOpD,
          JumpD, ALUResultSrcD, CSRReadD, PrivilegedD, fenceXD} =
         IllegalIEUInstrD ? '0 : ctrlWordD[18:1];  // Squash on upstream illegal
  assign IllegalBaseInstrD = ctrlWordD[0];

  //////////////////////////////
  // ALU and side decode

  assign ALUSelectD = aluOpD ? Funct3D : aluAdd;  // Loads, stores, jumps add
  assign subD       = (Funct3D == f3AddSub) & funct7D[5] & opD[5];  // opD[5] keeps addi out
  assign sraD       = (Funct3D == f3Sr) & funct7D[5];
  assign sltD       = (Funct3D == f3Slt);
  assign sltuD      = (Funct3D == f3Sltu);
  assign SubArithD  = aluOpD & (subD | sraD | sltD | sltuD);

  // Set/clear with zero source (rs1 or uimm) only reads
  assign CSRWriteD = CSRReadD & ~(InstrD[13] & (Rs1D == regZero));
  assign FenceID   = fenceXD & (Funct3D == f3FenceI);  // Plain fence is a nop

endmodule

`default_nettype wire

// File: rtl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

  //////////////////////////////
  // Instruction fields

  typedef logic [31:0] instrT;    // One RV32 instruction word
  typedef logic [4:0]  regAddrT;  // Integer register index
  typedef logic [6:0]  opcodeT;   // Major opcode, bits 6:0
  typedef logic [2:0]  funct3T;   // Minor opcode, bits 14:12
  typedef logic [6:0]  funct7T;   // Upper function, bits 31:25

  //////////////////////////////
  // Major opcodes, RV32I + Zicsr + Zifencei

  localparam opcodeT opLoad    = 7'b0000011;  // lb lh lw lbu lhu
  localparam opcodeT opMiscMem = 7'b0001111;  // fence, fence.i
  localparam opcodeT opOpImm   = 7'b0010011;  // I-type ALU
  localparam opcodeT opAuipc   = 7'b0010111;
  localparam opcodeT opStore   = 7'b0100011;  // sb sh sw
  localparam opcodeT opOp      = 7'b0110011;  // R-type ALU
  localparam opcodeT opLui     = 7'b0110111;
  localparam opcodeT opBranch  = 7'b1100011;
  localparam opcodeT opJalr    = 7'b1100111;
  localparam opcodeT opJal     = 7'b1101111;
  localparam opcodeT opSystem  = 7'b1110011;  // Privileged and CSR

  //////////////////////////////
  // Minor opcodes

  localparam funct7T funct7Zero = 7'b0000000;  // Plain R-type and shifts
  localparam funct7T funct7Alt  = 7'b0100000;  // sub, sra, srai

  localparam funct3T f3AddSub = 3'b000;  // Also jalr
  localparam funct3T f3Sll    = 3'b001;
  localparam funct3T f3Slt    = 3'b010;
  localparam funct3T f3Sltu   = 3'b011;
  localparam funct3T f3Sr     = 3'b101;  // srl/sra, funct7 picks which
  localparam funct3T f3Fence  = 3'b000;
  localparam funct3T f3FenceI = 3'b001;
  localparam funct3T f3Priv   = 3'b000;  // ecall, ebreak, mret, wfi

  localparam regAddrT regZero = 5'd0;  // Hardwired zero

endpackage

`default_nettype wire

// File: verilog.f
rtl/rvIsaPkg.sv
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/ctrlPipe.sv
rtl/hazardUnit.sv
rtl/controller.sv
dv/controllerTb.sv
